// File: sim.f
design/tetris_pkg.sv
design/playfield_store.sv
design/playfield_arbiter.sv
design/piece_locker.sv
design/line_clearer.sv
design/garbage_loader.sv
design/playfield_top.sv
verification/playfield_sva.sv
verification/playfield_tb.sv

// File: Makefile
# Verilator build and run for the playfield testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module playfield_tb -f sim.f
	./obj_dir/Vplayfield_tb | tee sim.log
	grep -q "^Verification passed$$" sim.log

lint:
	verilator --lint-only --timing --top-module playfield_tb -f sim.f

clean:
	rm -rf obj_dir sim.log

// File: verification/playfield_tb.sv
/* Playfield testbench: directed lock, line clear, garbage and contention
   tests checked against a reference model of the grid */

`default_nettype none

module playfield_tb;

    localparam int ROWS = tetris_pkg::PLAYFIELD_ROWS;
    localparam int COLS = tetris_pkg::PLAYFIELD_COLS;
    localparam int ROW_W = tetris_pkg::ROW_W;
    localparam int COL_W = tetris_pkg::COL_W;
    localparam int PENDING_W = tetris_pkg::PENDING_W;
    // about a dozen grid scans of 20 cycles plus the operations, with a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   game_start;
    logic                   lock;
    tetris_pkg::tile_t      lock_type;
    logic [ROW_W-1:0]       lock_rows [4];
    logic [COL_W-1:0]       lock_cols [4];
    logic                   garbage;
    logic [PENDING_W-1:0]   garbage_count;
    logic [ROW_W-1:0]       read_row;
    tetris_pkg::tile_t      read_tiles [COLS];
    logic                   locker_busy;
    logic [9:0]             lines_cleared;
    logic [PENDING_W-1:0]   pending_garbage;

    // expected grid and the cells of the next piece
    logic [3:0]             model [ROWS][COLS];
    logic [ROW_W-1:0]       pr [4];
    logic [COL_W-1:0]       pc [4];
    int                     exp_lines = 0;
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     cycles = 0;
    integer                 seed;

    playfield_top #(
        .HOLE_SEED      (16'h5a3c)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .game_start     (game_start),
        .lock           (lock),
        .lock_type      (lock_type),
        .lock_rows      (lock_rows),
        .lock_cols      (lock_cols),
        .garbage        (garbage),
        .garbage_count  (garbage_count),
        .read_row       (read_row),
        .read_tiles     (read_tiles),
        .locker_busy    (locker_busy),
        .lines_cleared  (lines_cleared),
        .pending_garbage(pending_garbage)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic model_clear();
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                model[r][c] = 4'd0;
            end
        end
    endtask

    task automatic model_lock(input logic [3:0] typ);
        for (int i = 0; i < 4; i++) begin
            model[pr[i]][pc[i]] = typ;
        end
    endtask

    // bottom-most full row goes first, and the same row is looked at again
    task automatic model_collapse();
        logic full;
        int r;
        r = ROWS - 1;
        while (r >= 0) begin
            full = 1'b1;
            for (int c = 0; c < COLS; c++) begin
                if (model[r][c] == 4'd0) begin
                    full = 1'b0;
                end
            end
            if (full) begin
                for (int k = r; k > 0; k--) begin
                    for (int c = 0; c < COLS; c++) begin
                        model[k][c] = model[k - 1][c];
                    end
                end
                for (int c = 0; c < COLS; c++) begin
                    model[0][c] = 4'd0;
                end
                exp_lines++;
            end else begin
                r--;
            end
        end
    endtask

    // hole columns are filled in later from what the DUT shows
    task automatic model_raise(input int n);
        for (int k = 0; k < n; k++) begin
            for (int r = 0; r < ROWS - 1; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    model[r][c] = model[r + 1][c];
                end
            end
            for (int c = 0; c < COLS; c++) begin
                model[ROWS - 1][c] = tetris_pkg::GARBAGE;
            end
        end
    endtask

    task automatic set_cells(input int r0, c0, r1, c1, r2, c2, r3, c3);
        pr[0] = ROW_W'(r0);
        pc[0] = COL_W'(c0);
        pr[1] = ROW_W'(r1);
        pc[1] = COL_W'(c1);
        pr[2] = ROW_W'(r2);
        pc[2] = COL_W'(c2);
        pr[3] = ROW_W'(r3);
        pc[3] = COL_W'(c3);
    endtask

    task automatic drive_piece(input logic [3:0] typ);
        lock <= 1'b1;
        lock_type <= tetris_pkg::tile_t'(typ);
        for (int i = 0; i < 4; i++) begin
            lock_rows[i] <= pr[i];
            lock_cols[i] <= pc[i];
        end
    endtask

    // returns on the edge that samples the pulse
    task automatic send_lock(input logic [3:0] typ);
        @(posedge clk);
        drive_piece(typ);
        @(posedge clk);
        lock <= 1'b0;
    endtask

    task automatic send_garbage(input int n);
        @(posedge clk);
        garbage <= 1'b1;
        garbage_count <= PENDING_W'(n);
        @(posedge clk);
        garbage <= 1'b0;
    endtask

    task automatic pulse_game_start();
        @(posedge clk);
        game_start <= 1'b1;
        @(posedge clk);
        game_start <= 1'b0;
        model_clear();
        exp_lines = 0;
    endtask

    task automatic settle();
        @(negedge clk);
        while (locker_busy || pending_garbage != 0 || int'(lines_cleared) != exp_lines) begin
            @(negedge clk);
        end
    endtask

    task automatic lock_and_settle(input logic [3:0] typ);
        send_lock(typ);
        model_lock(typ);
        model_collapse();
        settle();
    endtask

    task automatic read_at(input int r);
        @(posedge clk);
        read_row <= ROW_W'(r);
        @(negedge clk);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_grid();
        for (int r = 0; r < ROWS; r++) begin
            read_at(r);
            for (int c = 0; c < COLS; c++) begin
                checks++;
                assert (read_tiles[c] == model[r][c]) else begin
                    $display("FAIL read_tiles[%0d] at read_row %0d: got %h, expected %h",
                             c, r, read_tiles[c], model[r][c]);
                    errors++;
                end
            end
        end
    endtask

    task automatic check_status();
        check_value("locker_busy", int'(locker_busy), 0);
        check_value("lines_cleared", int'(lines_cleared), exp_lines);
        check_value("pending_garbage", int'(pending_garbage), 0);
    endtask

    // each new bottom row needs one blank among garbage, then the model takes it
    task automatic record_holes(input int n);
        int blanks;
        int garb;
        int hole;
        for (int r = ROWS - n; r < ROWS; r++) begin
            read_at(r);
            blanks = 0;
            garb = 0;
            hole = 0;
            for (int c = 0; c < COLS; c++) begin
                if (read_tiles[c] == tetris_pkg::BLANK) begin
                    blanks++;
                    hole = c;
                end else if (read_tiles[c] == tetris_pkg::GARBAGE) begin
                    garb++;
                end
            end
            checks++;
            assert (blanks == 1 && garb == COLS - 1) else begin
                $display("garbage row %0d does not hold one hole among garbage tiles", r);
                errors++;
            end
            model[r][hole] = 4'd0;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        model_clear();
        check_grid();
        check_status();
        set_cells(19, 0, 19, 1, 19, 2, 19, 3);
        lock_and_settle(tetris_pkg::I);
        set_cells(19, 4, 19, 5, 19, 6, 19, 7);
        lock_and_settle(tetris_pkg::I);
        set_cells(19, 8, 19, 9, 3, 0, 3, 1);
        lock_and_settle(tetris_pkg::O);
        // garbage is still being raised when the pulse lands
        send_garbage(5);
        pulse_game_start();
        check_grid();
        check_status();
        end_test("reset", e0);
    endtask

    // column 9 stays empty so no row can fill
    task automatic test_lock();
        int e0;
        int typ;
        e0 = errors;
        for (int n = 0; n < 5; n++) begin
            for (int i = 0; i < 4; i++) begin
                pr[i] = ROW_W'($unsigned($random(seed)) % ROWS);
                pc[i] = COL_W'($unsigned($random(seed)) % (COLS - 1));
            end
            typ = 1 + int'($unsigned($random(seed)) % 7);
            send_lock(4'(typ));
            model_lock(4'(typ));
            @(negedge clk);
            check_value("locker_busy", int'(locker_busy), 1);
            @(negedge clk);
            check_value("locker_busy", int'(locker_busy), 0);
            check_grid();
        end
        end_test("lock", e0);
    endtask

    task automatic test_line_clear();
        int e0;
        e0 = errors;
        pulse_game_start();
        set_cells(17, 0, 17, 1, 17, 2, 16, 1);
        lock_and_settle(tetris_pkg::T);
        set_cells(19, 0, 19, 1, 19, 2, 19, 3);
        lock_and_settle(tetris_pkg::I);
        set_cells(19, 4, 19, 5, 19, 6, 19, 7);
        lock_and_settle(tetris_pkg::I);
        set_cells(19, 8, 19, 9, 18, 8, 18, 9);
        lock_and_settle(tetris_pkg::O);
        check_value("lines_cleared", int'(lines_cleared), 1);
        check_grid();
        // the last piece completes rows 18 and 19 together
        set_cells(18, 3, 18, 4, 18, 5, 18, 6);
        lock_and_settle(tetris_pkg::J);
        set_cells(19, 0, 19, 1, 19, 2, 19, 3);
        lock_and_settle(tetris_pkg::L);
        set_cells(19, 4, 19, 5, 19, 6, 18, 7);
        lock_and_settle(tetris_pkg::S);
        set_cells(19, 7, 18, 8, 18, 9, 17, 9);
        lock_and_settle(tetris_pkg::Z);
        check_value("lines_cleared", int'(lines_cleared), 3);
        check_grid();
        end_test("line_clear", e0);
    endtask

    task automatic test_garbage();
        int e0;
        e0 = errors;
        send_garbage(3);
        model_raise(3);
        @(negedge clk);
        check_value("pending_garbage", int'(pending_garbage), 3);
        settle();
        record_holes(3);
        check_grid();
        check_status();
        end_test("garbage", e0);
    endtask

    task automatic test_contention();
        int e0;
        e0 = errors;
        set_cells(5, 2, 5, 3, 6, 3, 6, 4);
        @(posedge clk);
        drive_piece(tetris_pkg::S);
        garbage <= 1'b1;
        garbage_count <= PENDING_W'(2);
        model_lock(tetris_pkg::S);
        model_raise(2);
        // a second piece while the first is still held
        @(posedge clk);
        garbage <= 1'b0;
        set_cells(2, 7, 2, 8, 3, 8, 3, 9);
        drive_piece(tetris_pkg::Z);
        @(negedge clk);
        checks++;
        assert (locker_busy) else begin
            $display("second lock pulse did not meet a busy locker");
            errors++;
        end
        @(posedge clk);
        lock <= 1'b0;
        settle();
        record_holes(2);
        check_grid();
        check_status();
        end_test("contention", e0);
    endtask

    initial begin
        reset <= 1'b1;
        game_start <= 1'b0;
        lock <= 1'b0;
        lock_type <= tetris_pkg::BLANK;
        garbage <= 1'b0;
        garbage_count <= '0;
        read_row <= '0;
        for (int i = 0; i < 4; i++) begin
            lock_rows[i] <= '0;
            lock_cols[i] <= '0;
        end
        seed = 32'hac96ad65;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_lock();
        test_line_clear();
        test_garbage();
        test_contention();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/playfield_sva.sv
/* Playfield checks on the arbiter grants and the store operation */

`default_nettype none

module playfield_sva (
    input logic                 clk,
    input logic                 reset,
    input logic                 clear_req,
    input logic                 lock_req,
    input logic                 raise_req,
    input logic                 clear_gnt,
    input logic                 lock_gnt,
    input logic                 raise_gnt,
    input tetris_pkg::pf_op_t   op
);

    one_grant: assert property (@(posedge clk) disable iff (reset)
        $onehot0({clear_gnt, lock_gnt, raise_gnt}))
        else $error("more than one grant in a cycle");

    grant_needs_request: assert property (@(posedge clk) disable iff (reset)
        (!clear_gnt || clear_req) && (!lock_gnt || lock_req) && (!raise_gnt || raise_req))
        else $error("grant given without a request");

    // the store must see no operation while the grid is idle
    nop_when_idle: assert property (@(posedge clk) disable iff (reset)
        !(clear_gnt || lock_gnt || raise_gnt) |-> op == tetris_pkg::PF_NOP)
        else $error("store operation issued without a grant");

endmodule

bind playfield_top playfield_sva i_sva (
    .clk        (clk),
    .reset      (reset),
    .clear_req  (clear_req),
    .lock_req   (locker_busy),
    .raise_req  (raise_req),
    .clear_gnt  (clear_gnt),
    .lock_gnt   (lock_gnt),
    .raise_gnt  (raise_gnt),
    .op         (op)
);

`default_nettype wire

// File: design/playfield_top.sv
/* Playfield top: the grid store shared by the line clearer, piece locker
   and garbage loader through a fixed-priority arbiter */

`default_nettype none

module playfield_top #(
    parameter logic [15:0] HOLE_SEED = 16'hace1
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                game_start,
    input  logic                                lock,
    input  tetris_pkg::tile_t                   lock_type,
    input  logic [tetris_pkg::ROW_W-1:0]        lock_rows [4],
    input  logic [tetris_pkg::COL_W-1:0]        lock_cols [4],
    input  logic                                garbage,
    input  logic [tetris_pkg::PENDING_W-1:0]    garbage_count,
    input  logic [tetris_pkg::ROW_W-1:0]        read_row,
    output tetris_pkg::tile_t                   read_tiles [tetris_pkg::PLAYFIELD_COLS],
    output logic                                locker_busy,
    output logic [9:0]                          lines_cleared,
    output logic [tetris_pkg::PENDING_W-1:0]    pending_garbage
);

    logic                                   clear_req;
    logic                                   clear_gnt;
    logic                                   lock_gnt;
    logic                                   raise_req;
    logic                                   raise_gnt;
    tetris_pkg::pf_op_t                     op;
    logic [tetris_pkg::ROW_W-1:0]           cell_rows [4];
    logic [tetris_pkg::COL_W-1:0]           cell_cols [4];
    tetris_pkg::tile_t                      cell_type;
    logic [tetris_pkg::ROW_W-1:0]           collapse_row;
    logic [tetris_pkg::COL_W-1:0]           hole_col;
    logic [tetris_pkg::PLAYFIELD_ROWS-1:0]  row_full;

    playfield_store i_store (
        .clk            (clk),
        .reset          (reset),
        .game_start     (game_start),
        .op             (op),
        .cell_rows      (cell_rows),
        .cell_cols      (cell_cols),
        .cell_type      (cell_type),
        .collapse_row   (collapse_row),
        .hole_col       (hole_col),
        .read_row       (read_row),
        .read_tiles     (read_tiles),
        .row_full       (row_full)
    );

    playfield_arbiter i_arbiter (
        .clear_req      (clear_req),
        .lock_req       (locker_busy),
        .raise_req      (raise_req),
        .clear_gnt      (clear_gnt),
        .lock_gnt       (lock_gnt),
        .raise_gnt      (raise_gnt),
        .op             (op)
    );

    // the lock request level is also the busy flag
    piece_locker i_locker (
        .clk            (clk),
        .reset          (reset),
        .game_start     (game_start),
        .lock           (lock),
        .lock_type      (lock_type),
        .lock_rows      (lock_rows),
        .lock_cols      (lock_cols),
        .lock_gnt       (lock_gnt),
        .lock_req       (locker_busy),
        .cell_rows      (cell_rows),
        .cell_cols      (cell_cols),
        .cell_type      (cell_type)
    );

    line_clearer i_clearer (
        .clk            (clk),
        .reset          (reset),
        .game_start     (game_start),
        .row_full       (row_full),
        .clear_gnt      (clear_gnt),
        .clear_req      (clear_req),
        .collapse_row   (collapse_row),
        .lines_cleared  (lines_cleared)
    );

    garbage_loader #(
        .HOLE_SEED      (HOLE_SEED)
    ) i_garbage (
        .clk            (clk),
        .reset          (reset),
        .game_start     (game_start),
        .garbage        (garbage),
        .garbage_count  (garbage_count),
        .raise_gnt      (raise_gnt),
        .raise_req      (raise_req),
        .hole_col       (hole_col),
        .pending_garbage(pending_garbage)
    );

endmodule

`default_nettype wire

// File: design/garbage_loader.sv
/* Garbage loader: keeps the pending garbage count and requests one
   raise per line, with LFSR-picked hole columns */

`default_nettype none

module garbage_loader #(
    parameter logic [15:0] HOLE_SEED = 16'hace1
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                game_start,
    input  logic                                garbage,
    input  logic [tetris_pkg::PENDING_W-1:0]    garbage_count,
    input  logic                                raise_gnt,
    output logic                                raise_req,
    output logic [tetris_pkg::COL_W-1:0]        hole_col,
    output logic [tetris_pkg::PENDING_W-1:0]    pending_garbage
);

    logic [15:0]                        lfsr;
    logic                               feedback;
    logic [15:0]                        hole_mod;
    logic [tetris_pkg::PENDING_W-1:0]   after_raise;
    logic [tetris_pkg::PENDING_W:0]     sum;
    logic [tetris_pkg::PENDING_W-1:0]   pending_next;

    assign raise_req = |pending_garbage;

    // taps 16,14,13,11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    assign hole_mod = lfsr % 16'(tetris_pkg::PLAYFIELD_COLS);
    assign hole_col = hole_mod[tetris_pkg::COL_W-1:0];

    // take the granted line off first, then add the new strobe and saturate
    always_comb begin
        after_raise = pending_garbage - {{(tetris_pkg::PENDING_W-1){1'b0}}, raise_gnt};
        sum = {1'b0, after_raise};
        if (garbage) begin
            sum = {1'b0, after_raise} + {1'b0, garbage_count};
        end
        if (sum[tetris_pkg::PENDING_W]) begin
            pending_next = '1;
        end else begin
            pending_next = sum[tetris_pkg::PENDING_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            pending_garbage <= '0;
        end else begin
            pending_garbage <= pending_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= HOLE_SEED;
        end else if (raise_gnt) begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

endmodule

`default_nettype wire

// File: design/line_clearer.sv
/* Line clearer: picks the bottom-most full row, requests its collapse
   and counts cleared lines */

`default_nettype none

module line_clearer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    game_start,
    input  logic [tetris_pkg::PLAYFIELD_ROWS-1:0]   row_full,
    input  logic                                    clear_gnt,
    output logic                                    clear_req,
    output logic [tetris_pkg::ROW_W-1:0]            collapse_row,
    output logic [9:0]                              lines_cleared
);

    assign clear_req = |row_full;

    // higher row index is lower on screen, so the last hit wins
    always_comb begin
        collapse_row = '0;
        for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
            if (row_full[r]) begin
                collapse_row = r[tetris_pkg::ROW_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            lines_cleared <= '0;
        end else if (clear_gnt) begin
            lines_cleared <= lines_cleared + 10'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/piece_locker.sv
/* Piece locker: holds one lock strobe's tiles and type and requests
   the grid until the write is granted */

`default_nettype none

module piece_locker (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            game_start,
    input  logic                            lock,
    input  tetris_pkg::tile_t               lock_type,
    input  logic [tetris_pkg::ROW_W-1:0]    lock_rows [4],
    input  logic [tetris_pkg::COL_W-1:0]    lock_cols [4],
    input  logic                            lock_gnt,
    output logic                            lock_req,
    output logic [tetris_pkg::ROW_W-1:0]    cell_rows [4],
    output logic [tetris_pkg::COL_W-1:0]    cell_cols [4],
    output tetris_pkg::tile_t               cell_type
);

    logic accept;

    // a strobe while a lock is held is dropped
    assign accept = lock && !lock_req;

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            lock_req <= 1'b0;
        end else if (lock_req && lock_gnt) begin
            lock_req <= 1'b0;
        end else if (accept) begin
            lock_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cell_rows <= lock_rows;
            cell_cols <= lock_cols;
            cell_type <= lock_type;
        end
    end

endmodule

`default_nettype wire

// File: design/playfield_arbiter.sv
/* Playfield arbiter: fixed-priority grant of the grid to the clearer,
   the locker and the garbage loader, and the matching store operation */

`default_nettype none

module playfield_arbiter (
    input  logic                clear_req,
    input  logic                lock_req,
    input  logic                raise_req,
    output logic                clear_gnt,
    output logic                lock_gnt,
    output logic                raise_gnt,
    output tetris_pkg::pf_op_t  op
);

    // clearer beats locker beats garbage
    assign clear_gnt = clear_req;
    assign lock_gnt  = lock_req && !clear_req;
    assign raise_gnt = raise_req && !clear_req && !lock_req;

    always_comb begin
        if (clear_gnt) begin
            op = tetris_pkg::PF_COLLAPSE;
        end else if (lock_gnt) begin
            op = tetris_pkg::PF_LOCK;
        end else if (raise_gnt) begin
            op = tetris_pkg::PF_RAISE;
        end else begin
            op = tetris_pkg::PF_NOP;
        end
    end

endmodule

`default_nettype wire

// File: design/playfield_store.sv
/* Playfield store: the locked-tile grid, applying one granted operation
   per cycle, with per-row full flags and a single row read port */

`default_nettype none

module playfield_store (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                game_start,
    input  tetris_pkg::pf_op_t                  op,
    input  logic [tetris_pkg::ROW_W-1:0]        cell_rows [4],
    input  logic [tetris_pkg::COL_W-1:0]        cell_cols [4],
    input  tetris_pkg::tile_t                   cell_type,
    input  logic [tetris_pkg::ROW_W-1:0]        collapse_row,
    input  logic [tetris_pkg::COL_W-1:0]        hole_col,
    input  logic [tetris_pkg::ROW_W-1:0]        read_row,
    output tetris_pkg::tile_t                   read_tiles [tetris_pkg::PLAYFIELD_COLS],
    output logic [tetris_pkg::PLAYFIELD_ROWS-1:0] row_full
);

    tetris_pkg::tile_t grid [tetris_pkg::PLAYFIELD_ROWS][tetris_pkg::PLAYFIELD_COLS];

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                    grid[r][c] <= tetris_pkg::BLANK;
                end
            end
        end else begin
            case (op)
                tetris_pkg::PF_LOCK: begin
                    // overlapping tiles are simply overwritten
                    for (int i = 0; i < 4; i++) begin
                        if (int'(cell_rows[i]) < tetris_pkg::PLAYFIELD_ROWS &&
                            int'(cell_cols[i]) < tetris_pkg::PLAYFIELD_COLS) begin
                            grid[cell_rows[i]][cell_cols[i]] <= cell_type;
                        end
                    end
                end
                tetris_pkg::PF_COLLAPSE: begin
                    // rows above the cleared one drop by one, top row empties
                    for (int r = 1; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                        if (r <= int'(collapse_row)) begin
                            grid[r] <= grid[r - 1];
                        end
                    end
                    for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                        grid[0][c] <= tetris_pkg::BLANK;
                    end
                end
                tetris_pkg::PF_RAISE: begin
                    for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS - 1; r++) begin
                        grid[r] <= grid[r + 1];
                    end
                    for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                        grid[tetris_pkg::PLAYFIELD_ROWS - 1][c] <=
                            (c == int'(hole_col)) ? tetris_pkg::BLANK : tetris_pkg::GARBAGE;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // a row is full when no cell is blank
    always_comb begin
        for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
            row_full[r] = 1'b1;
            for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                if (grid[r][c] == tetris_pkg::BLANK) begin
                    row_full[r] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
            if (int'(read_row) < tetris_pkg::PLAYFIELD_ROWS) begin
                read_tiles[c] = grid[read_row][c];
            end else begin
                read_tiles[c] = tetris_pkg::BLANK;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/tetris_pkg.sv
/* Tetris playfield definitions: grid dimensions, index widths,
   tile contents and the store operations */

`default_nettype none

package tetris_pkg;

    // grid size, row 0 is the top
    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;

    // index widths
    localparam int ROW_W = 5;
    localparam int COL_W = 4;

    // pending garbage lines, saturates at 31
    localparam int PENDING_W = 5;

    // tile contents of one grid cell
    typedef enum logic [3:0] {
        BLANK   = 4'd0,
        I,
        O,
        T,
        J,
        L,
        S,
        Z,
        GARBAGE
    } tile_t;

    // one store operation per cycle
    typedef enum logic [1:0] {
        PF_NOP,
        PF_LOCK,
        PF_COLLAPSE,
        PF_RAISE
    } pf_op_t;

endpackage

`default_nettype wire
